//--- burst_detect.f
hw/burst_detect_pkg.sv
hw/stream_fifo.sv
hw/preamble_corr.sv
hw/cordic_vec.sv
hw/peak_finder.sv
hw/burst_detect_top.sv
tb/burst_detect_props.sv
tb/burst_detect_tb.sv

//--- tb/burst_detect_tb.sv
`timescale 1ns/1ps

module burst_detect_tb
   import burst_detect_pkg::*;
();

   localparam int LAG           = 16;
   localparam int WIN           = 16;
   localparam int CORDIC_STAGES = 12;
   localparam int FIFO_DEPTH    = 16;
   localparam int SCALAR        = 131072;

   localparam int GAP       = 48;
   localparam int BURST_LEN = 8 * LAG;
   localparam int PHASE_TOL = 128;
   localparam real PI       = 3.14159265358979;
   localparam real AMP      = 8000.0;

   // samples per test, in run order
   localparam int NOISE_LEN     = 400;
   localparam int ONE_BURST_LEN = 2 * GAP + BURST_LEN;
   localparam int TWO_BURST_LEN = 3 * GAP + 2 * BURST_LEN;
   localparam int CLEAR_LEN     = 3 * GAP + BURST_LEN / 2 + BURST_LEN;
   localparam int TOTAL_SAMPLES = NOISE_LEN + 3 * ONE_BURST_LEN + TWO_BURST_LEN + CLEAR_LEN;
   localparam int CYCLE_LIMIT   = TOTAL_SAMPLES * 4 + 2000;

   localparam int MAX_IN_FLIGHT = FIFO_DEPTH + CORDIC_STAGES + 6;
   localparam int DRAIN_LIMIT   = 500;

   logic   clk;
   logic   i_rst;
   logic   i_clear;
   iq_t    i_sample;
   logic   i_valid;
   logic   o_ready;
   burst_t o_burst;
   logic   o_last;
   logic   o_valid;
   logic   i_ready;

   integer seed = 32'h52d007fa;
   logic   stall_en;
   int     value_errs;
   int     other_errs;
   int     sent_count;
   int     beat_count;
   int     cycle_count;
   burst_t events [$];

   burst_detect_top
   #(
      .LAG(LAG), .WIN(WIN), .CORDIC_STAGES(CORDIC_STAGES),
      .FIFO_DEPTH(FIFO_DEPTH), .SCALAR(SCALAR)
   ) dut
   (
      .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
      .i_sample(i_sample), .i_valid(i_valid), .o_ready(o_ready),
      .o_burst(o_burst), .o_last(o_last), .o_valid(o_valid), .i_ready(i_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // output side back-pressure, random only while enabled
   always @(negedge clk)
   begin
      if (stall_en)
         i_ready = ($random(seed) & 1) ? 1'b1 : 1'b0;
      else
         i_ready = 1'b1;
   end

   // output beats, sampled once inputs have settled after the falling edge
   always
   begin
      @(negedge clk);
      #1;
      if (!i_rst && o_valid && i_ready)
      begin
         beat_count++;
         if (o_last)
            events.push_back(o_burst);
      end
   end

   task automatic print_error_counts();
      $display("error counts: %0d value, %0d other, %0d assertion",
               value_errs, other_errs, dut.u_props.fail_count);
   endtask

   initial
   begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the tests never finished", cycle_count);
      print_error_counts();
      $display("Test failures found");
      $finish;
   end

   task automatic report_mismatch(input string msg);
      $display("[ERROR] %0t: %s", $time, msg);
      value_errs++;
   endtask

   // model of the reported phase, turns mapped onto 65536 counts
   function automatic logic [15:0] expected_phase(input real lag_turns);
      real counts;
      counts = lag_turns * 65536.0;
      return 16'(int'(counts));
   endfunction

   // period LAG phase pattern, rotated by lag_turns every LAG samples
   function automatic iq_t preamble_sample(input int n, input real lag_turns);
      iq_t s;
      int  k;
      real ang;
      k   = n % LAG;
      ang = real'((k * k * 5) % LAG) / real'(LAG);
      ang = 2.0 * PI * (ang + lag_turns * real'(n) / real'(LAG));
      s.i = SAMPLE_W'(int'(AMP * $cos(ang)));
      s.q = SAMPLE_W'(int'(AMP * $sin(ang)));
      return s;
   endfunction

   task automatic send_sample(input iq_t s);
      @(negedge clk);
      i_sample = s;
      i_valid  = 1'b1;
      #1;
      while (!o_ready)
      begin
         @(negedge clk);
         #1;
      end
      @(posedge clk);
      sent_count++;
   endtask

   task automatic send_quiet(input int n);
      for (int k = 0; k < n; k++)
         send_sample('0);
   endtask

   task automatic send_noise(input int n);
      iq_t s;
      for (int k = 0; k < n; k++)
      begin
         s.i = SAMPLE_W'($random(seed) % 5);
         s.q = SAMPLE_W'($random(seed) % 5);
         send_sample(s);
      end
   endtask

   task automatic send_burst(input int len, input real lag_turns);
      for (int n = 0; n < len; n++)
         send_sample(preamble_sample(n, lag_turns));
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      @(negedge clk);
      i_valid = 1'b0;
      while (beat_count != sent_count && waited < DRAIN_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (beat_count != sent_count)
      begin
         $display("%0t: output stalled with %0d of %0d samples delivered",
                  $time, beat_count, sent_count);
         other_errs++;
      end
   endtask

   task automatic pulse_clear();
      @(negedge clk);
      i_valid = 1'b0;
      i_clear = 1'b1;
      @(negedge clk);
      i_clear = 1'b0;
      // samples in flight were dropped
      sent_count = beat_count;
   endtask

   task automatic check_event(input burst_t ev, input real lag_turns, input string name);
      logic [15:0]        exp_phase;
      logic signed [15:0] diff;
      int                 lo;
      int                 hi;
      exp_phase = expected_phase(lag_turns);
      diff      = ev.phase - exp_phase;
      lo        = DEBOUNCE + 1;
      hi        = BURST_LEN + WIN + DEBOUNCE + 1;
      if (diff > PHASE_TOL || diff < -PHASE_TOL)
         report_mismatch($sformatf("%s: phase %0d, expected %0d", name, ev.phase, exp_phase));
      if (ev.offset < lo || ev.offset > hi)
         report_mismatch($sformatf("%s: offset %0d outside %0d..%0d", name, ev.offset, lo, hi));
   endtask

   task automatic noise_only();
      int first;
      first = events.size();
      send_noise(NOISE_LEN / 2);
      send_quiet(NOISE_LEN / 2);
      if (beat_count > sent_count || sent_count - beat_count > MAX_IN_FLIGHT)
         report_mismatch($sformatf("noise: %0d beats for %0d samples", beat_count, sent_count));
      wait_drain();
      if (events.size() != first)
         report_mismatch($sformatf("noise: %0d unexpected reports", events.size() - first));
   endtask

   task automatic single_burst(input real lag_turns, input string name, output burst_t ev);
      int first;
      first = events.size();
      ev    = '0;
      send_quiet(GAP);
      send_burst(BURST_LEN, lag_turns);
      send_quiet(GAP);
      wait_drain();
      if (events.size() != first + 1)
      begin
         report_mismatch($sformatf("%s: %0d reports, expected 1", name, events.size() - first));
      end
      else
      begin
         ev = events[first];
         check_event(ev, lag_turns, name);
      end
   endtask

   task automatic two_bursts();
      int first;
      first = events.size();
      send_quiet(GAP);
      send_burst(BURST_LEN, 0.125);
      send_quiet(GAP);
      send_burst(BURST_LEN, 0.8);
      send_quiet(GAP);
      wait_drain();
      if (events.size() != first + 2)
      begin
         report_mismatch($sformatf("two bursts: %0d reports, expected 2",
                                   events.size() - first));
      end
      else
      begin
         check_event(events[first], 0.125, "first of two");
         check_event(events[first + 1], 0.8, "second of two");
      end
   endtask

   task automatic stalled_burst(input burst_t ref_ev);
      burst_t ev;
      int     beats_before;
      int     sent_before;
      beats_before = beat_count;
      sent_before  = sent_count;
      stall_en     = 1'b1;
      single_burst(0.3, "stalled burst", ev);
      stall_en = 1'b0;
      if (ev !== ref_ev)
         report_mismatch($sformatf("stalled burst: event %h, unstalled %h", ev, ref_ev));
      if (beat_count - beats_before != sent_count - sent_before)
         report_mismatch($sformatf("stalled burst: %0d beats for %0d samples",
                                   beat_count - beats_before, sent_count - sent_before));
   endtask

   task automatic clear_mid_burst();
      int first;
      first = events.size();
      send_quiet(GAP);
      send_burst(BURST_LEN / 2, 0.0);
      pulse_clear();
      send_quiet(GAP);
      send_burst(BURST_LEN, 0.2);
      send_quiet(GAP);
      wait_drain();
      // only the clean burst may report
      if (events.size() != first + 1)
         report_mismatch($sformatf("clear: %0d reports, expected 1", events.size() - first));
      else
         check_event(events[first], 0.2, "burst after clear");
   endtask

   initial
   begin
      burst_t zero_ev;
      burst_t ref_ev;
      i_rst      = 1'b1;
      i_clear    = 1'b0;
      i_sample   = '0;
      i_valid    = 1'b0;
      i_ready    = 1'b1;
      stall_en   = 1'b0;
      value_errs = 0;
      other_errs = 0;
      sent_count = 0;
      beat_count = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;

      noise_only();
      single_burst(0.0, "single burst", zero_ev);
      single_burst(0.3, "rotated burst", ref_ev);
      two_bursts();
      stalled_burst(ref_ev);
      clear_mid_burst();

      print_error_counts();
      if (value_errs + other_errs + dut.u_props.fail_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- tb/burst_detect_props.sv
`timescale 1ns/1ps

module burst_detect_props
   import burst_detect_pkg::*;
(
   input logic   clk,
   input logic   i_rst,
   input logic   i_clear,
   input logic   i_ready,
   input logic   o_valid,
   input logic   o_last,
   input burst_t o_burst
);

   int fail_count = 0;

   // a result waiting on the sink holds still
   stall_hold: assert property (@(posedge clk) disable iff (i_rst || i_clear)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_burst) && $stable(o_last)))
   else
   begin
      $error("output changed while stalled");
      fail_count++;
   end

   last_valid: assert property (@(posedge clk) disable iff (i_rst || i_clear)
      o_last |-> o_valid)
   else
   begin
      $error("o_last high without o_valid");
      fail_count++;
   end

   reset_idle: assert property (@(posedge clk) i_rst |=> (!o_valid && !o_last))
   else
   begin
      $error("output not idle after reset");
      fail_count++;
   end

endmodule

bind burst_detect_top burst_detect_props u_props
(
   .clk(clk), .i_rst(i_rst), .i_clear(i_clear), .i_ready(i_ready),
   .o_valid(o_valid), .o_last(o_last), .o_burst(o_burst)
);

//--- hw/burst_detect_top.sv
`timescale 1ns/1ps

module burst_detect_top
   import burst_detect_pkg::*;
#(
   parameter int LAG           = 16,
   parameter int WIN           = 16,
   parameter int CORDIC_STAGES = 12,
   parameter int FIFO_DEPTH    = 16,
   parameter int SCALAR        = 131072
)
(
   input  logic   clk,
   input  logic   i_rst,
   input  logic   i_clear,
   input  iq_t    i_sample,
   input  logic   i_valid,
   output logic   o_ready,
   output burst_t o_burst,
   output logic   o_last,
   output logic   o_valid,
   input  logic   i_ready
);

   iq_t       in_data;
   logic      in_valid;
   logic      in_ready;

   power_t    pwr_data;
   logic      pwr_valid;
   logic      pwr_ready;
   power_t    pwr_q_data;
   logic      pwr_q_valid;
   logic      pwr_q_ready;

   corr_t     corr_data;
   logic      corr_valid;
   logic      corr_ready;

   magphase_t mp_data;
   logic      mp_valid;
   logic      mp_ready;

   stream_fifo #(.T(iq_t), .DEPTH(FIFO_DEPTH)) u_in_fifo
   (
      .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
      .i_data(i_sample), .i_valid(i_valid), .o_ready(o_ready),
      .o_data(in_data), .o_valid(in_valid), .i_ready(in_ready)
   );

   preamble_corr #(.LAG(LAG), .WIN(WIN)) u_corr
   (
      .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
      .i_sample(in_data), .i_valid(in_valid), .o_ready(in_ready),
      .o_power(pwr_data), .o_power_valid(pwr_valid), .i_power_ready(pwr_ready),
      .o_corr(corr_data), .o_corr_valid(corr_valid), .i_corr_ready(corr_ready)
   );

   cordic_vec #(.STAGES(CORDIC_STAGES)) u_cordic
   (
      .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
      .i_corr(corr_data), .i_valid(corr_valid), .o_ready(corr_ready),
      .o_magphase(mp_data), .o_valid(mp_valid), .i_ready(mp_ready)
   );

   // power waits here while the CORDIC works
   stream_fifo #(.T(power_t), .DEPTH(FIFO_DEPTH)) u_pwr_fifo
   (
      .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
      .i_data(pwr_data), .i_valid(pwr_valid), .o_ready(pwr_ready),
      .o_data(pwr_q_data), .o_valid(pwr_q_valid), .i_ready(pwr_q_ready)
   );

   peak_finder #(.SCALAR(SCALAR)) u_peak
   (
      .clk(clk), .i_rst(i_rst), .i_clear(i_clear),
      .i_power(pwr_q_data), .i_power_valid(pwr_q_valid), .o_power_ready(pwr_q_ready),
      .i_magphase(mp_data), .i_mp_valid(mp_valid), .o_mp_ready(mp_ready),
      .o_burst(o_burst), .o_last(o_last), .o_valid(o_valid), .i_ready(i_ready)
   );

endmodule

//--- hw/peak_finder.sv
`timescale 1ns/1ps

module peak_finder
   import burst_detect_pkg::*;
#(
   parameter int SCALAR = 131072
)
(
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_clear,
   input  power_t    i_power,
   input  logic      i_power_valid,
   output logic      o_power_ready,
   input  magphase_t i_magphase,
   input  logic      i_mp_valid,
   output logic      o_mp_ready,
   output burst_t    o_burst,
   output logic      o_last,
   output logic      o_valid,
   input  logic      i_ready
);

   localparam logic signed [33:0] SCALAR_S = 34'(SCALAR);

   logic signed [MAG_W+1:0]  mag_m1;
   logic signed [MAG_W+35:0] scaled;
   logic                     thresh_met;
   logic                     do_op;

   logic [31:0]              counter;
   logic [7:0]               debounce;
   logic [MAG_W-1:0]         max_val;
   logic [PHASE_W-1:0]       max_phase;
   logic [31:0]              max_idx;
   logic                     peak_seen;

   // threshold test: (mag - 1) * SCALAR > power
   assign mag_m1     = $signed({2'b00, i_magphase.mag}) - 18'sd1;
   assign scaled     = mag_m1 * SCALAR_S;
   assign thresh_met = scaled > $signed({20'd0, i_power});

   // join of the two streams
   assign do_op         = i_power_valid && i_mp_valid && i_ready;
   assign o_valid       = i_power_valid && i_mp_valid;
   assign o_power_ready = do_op;
   assign o_mp_ready    = do_op;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         counter   <= '0;
         debounce  <= '0;
         max_val   <= '0;
         max_phase <= '0;
         max_idx   <= '0;
         peak_seen <= 1'b0;
         o_last    <= 1'b0;
         o_burst   <= '0;
      end
      else if (do_op)
      begin
         counter <= counter + 1'b1;
         o_last  <= 1'b0;
         o_burst <= '0;
         if (thresh_met || (debounce != '0))
         begin
            if (thresh_met)
            begin
               debounce <= 8'(DEBOUNCE);
            end
            else
            begin
               debounce <= debounce - 1'b1;
            end
            // strongest point of the crossing
            if (i_magphase.mag > max_val)
            begin
               max_val   <= i_magphase.mag;
               max_phase <= i_magphase.phase;
               max_idx   <= counter;
               peak_seen <= 1'b1;
            end
         end
         else if (peak_seen)
         begin
            // crossing over, report once
            o_last         <= 1'b1;
            o_burst.offset <= 16'(counter - max_idx);
            o_burst.phase  <= max_phase;
            max_val        <= '0;
            max_idx        <= '0;
            peak_seen      <= 1'b0;
         end
      end
   end

endmodule

//--- hw/cordic_vec.sv
`timescale 1ns/1ps

module cordic_vec
   import burst_detect_pkg::*;
#(
   parameter int STAGES = 12
)
(
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_clear,
   input  corr_t     i_corr,
   input  logic      i_valid,
   output logic      o_ready,
   output magphase_t o_magphase,
   output logic      o_valid,
   input  logic      i_ready
);

   // headroom for negation and the CORDIC gain of about 1.65
   localparam int XW = CORR_W + 2;
   // 1/K in 16 fractional bits
   localparam logic [16:0] GAIN_INV = 17'd39797;
   // gain fraction plus the corr to mag narrowing
   localparam int MAG_SHIFT = 16 + (CORR_W - MAG_W);
   localparam int PROD_W = XW + 17;

   typedef struct packed
   {
      logic signed [XW-1:0] x;
      logic signed [XW-1:0] y;
      logic [PHASE_W-1:0]   z;
   } rot_t;

   rot_t                  pre;
   rot_t                  stg [STAGES];
   logic [STAGES-1:0]     vld;
   logic                  adv;
   logic [PROD_W-1:0]     prod;
   logic [PROD_W-1:0]     mag_full;

   // atan(2^-s) in turn units
   function automatic logic [PHASE_W-1:0] atan_turn(input int s);
      case (s)
         0:       atan_turn = 16'd8192;
         1:       atan_turn = 16'd4836;
         2:       atan_turn = 16'd2555;
         3:       atan_turn = 16'd1297;
         4:       atan_turn = 16'd651;
         5:       atan_turn = 16'd326;
         6:       atan_turn = 16'd163;
         7:       atan_turn = 16'd81;
         8:       atan_turn = 16'd41;
         9:       atan_turn = 16'd20;
         10:      atan_turn = 16'd10;
         11:      atan_turn = 16'd5;
         12:      atan_turn = 16'd3;
         13:      atan_turn = 16'd1;
         14:      atan_turn = 16'd1;
         default: atan_turn = 16'd0;
      endcase
   endfunction

   // one micro-rotation toward y = 0
   function automatic rot_t iterate(input rot_t a, input int s);
      rot_t r;
      if (a.y[XW-1])
      begin
         r.x = a.x - (a.y >>> s);
         r.y = a.y + (a.x >>> s);
         r.z = a.z - atan_turn(s);
      end
      else
      begin
         r.x = a.x + (a.y >>> s);
         r.y = a.y - (a.x >>> s);
         r.z = a.z + atan_turn(s);
      end
      return r;
   endfunction

   // whole pipeline holds while the result waits
   assign adv     = !o_valid || i_ready;
   assign o_ready = adv;

   // fold the left half-plane over by half a turn
   always_comb
   begin
      pre.x = {{2{i_corr.re[CORR_W-1]}}, i_corr.re};
      pre.y = {{2{i_corr.im[CORR_W-1]}}, i_corr.im};
      pre.z = '0;
      if (i_corr.re[CORR_W-1])
      begin
         pre.x = -pre.x;
         pre.y = -pre.y;
         pre.z = 16'h8000;
      end
   end

   always_comb
   begin
      prod     = PROD_W'($unsigned(stg[STAGES-1].x)) * PROD_W'(GAIN_INV);
      mag_full = prod >> MAG_SHIFT;
   end

   always_ff @(posedge clk)
   begin
      if (adv)
      begin
         stg[0] <= iterate(pre, 0);
         for (int s = 1; s < STAGES; s++)
         begin
            stg[s] <= iterate(stg[s-1], s);
         end
         o_magphase.phase <= stg[STAGES-1].z;
         // saturate to 16 bits
         if (mag_full[PROD_W-1:MAG_W] != '0)
         begin
            o_magphase.mag <= '1;
         end
         else
         begin
            o_magphase.mag <= mag_full[MAG_W-1:0];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         vld     <= '0;
         o_valid <= 1'b0;
      end
      else if (adv)
      begin
         vld[0] <= i_valid;
         for (int s = 1; s < STAGES; s++)
         begin
            vld[s] <= vld[s-1];
         end
         o_valid <= vld[STAGES-1];
      end
   end

endmodule

//--- hw/preamble_corr.sv
`timescale 1ns/1ps

module preamble_corr
   import burst_detect_pkg::*;
#(
   parameter int LAG = 16,
   parameter int WIN = 16
)
(
   input  logic   clk,
   input  logic   i_rst,
   input  logic   i_clear,
   input  iq_t    i_sample,
   input  logic   i_valid,
   output logic   o_ready,
   output power_t o_power,
   output logic   o_power_valid,
   input  logic   i_power_ready,
   output corr_t  o_corr,
   output logic   o_corr_valid,
   input  logic   i_corr_ready
);

   localparam int LOG2W = $clog2(WIN);
   // per-sample product pair width
   localparam int TW = 2 * SAMPLE_W + 1;
   localparam int PW = 2 * SAMPLE_W + LOG2W;
   localparam int CW = TW + LOG2W;
   // keep the top CORR_W bits of the correlation sums
   localparam int CSH = CW - CORR_W;
   // one extra bit of power scaling puts the detection ratio near 0.5
   // against a threshold scale of 2**17
   localparam int PSH = LOG2W + 1;

   iq_t                   dly [LAG];
   logic [2*SAMPLE_W-1:0] pwr_hist [WIN];
   logic signed [TW-1:0]  cre_hist [WIN];
   logic signed [TW-1:0]  cim_hist [WIN];

   logic [PW-1:0]         psum;
   logic [PW-1:0]         psum_nxt;
   logic signed [CW-1:0]  cre_sum;
   logic signed [CW-1:0]  cim_sum;
   logic signed [CW-1:0]  cre_nxt;
   logic signed [CW-1:0]  cim_nxt;

   iq_t                   old;
   logic signed [TW-1:0]  pterm;
   logic signed [TW-1:0]  cre_term;
   logic signed [TW-1:0]  cim_term;
   logic                  take;

   // both output registers must have room
   assign o_ready = (!o_power_valid || i_power_ready) && (!o_corr_valid || i_corr_ready);
   assign take    = i_valid && o_ready;

   always_comb
   begin
      old = dly[LAG-1];
      // |x|^2
      pterm = i_sample.i * i_sample.i + i_sample.q * i_sample.q;
      // x times conj of the delayed sample
      cre_term = i_sample.i * old.i + i_sample.q * old.q;
      cim_term = i_sample.q * old.i - i_sample.i * old.q;

      // newest term in, oldest term out
      psum_nxt = psum + pterm[2*SAMPLE_W-1:0] - pwr_hist[WIN-1];
      cre_nxt  = cre_sum + cre_term - cre_hist[WIN-1];
      cim_nxt  = cim_sum + cim_term - cim_hist[WIN-1];
   end

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         dly      <= '{default: '0};
         pwr_hist <= '{default: '0};
         cre_hist <= '{default: '0};
         cim_hist <= '{default: '0};
         psum     <= '0;
         cre_sum  <= '0;
         cim_sum  <= '0;
      end
      else if (take)
      begin
         dly[0]      <= i_sample;
         pwr_hist[0] <= pterm[2*SAMPLE_W-1:0];
         cre_hist[0] <= cre_term;
         cim_hist[0] <= cim_term;
         for (int k = 1; k < LAG; k++)
         begin
            dly[k] <= dly[k-1];
         end
         for (int k = 1; k < WIN; k++)
         begin
            pwr_hist[k] <= pwr_hist[k-1];
            cre_hist[k] <= cre_hist[k-1];
            cim_hist[k] <= cim_hist[k-1];
         end
         psum    <= psum_nxt;
         cre_sum <= cre_nxt;
         cim_sum <= cim_nxt;
      end
   end

   // result registers
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         o_power   <= 32'(psum_nxt >> PSH);
         o_corr.re <= cre_nxt[CW-1:CSH];
         o_corr.im <= cim_nxt[CW-1:CSH];
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         o_power_valid <= 1'b0;
         o_corr_valid  <= 1'b0;
      end
      else
      begin
         if (take)
         begin
            o_power_valid <= 1'b1;
         end
         else if (i_power_ready)
         begin
            o_power_valid <= 1'b0;
         end

         if (take)
         begin
            o_corr_valid <= 1'b1;
         end
         else if (i_corr_ready)
         begin
            o_corr_valid <= 1'b0;
         end
      end
   end

endmodule

//--- hw/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo
#(
   parameter type T     = logic [31:0],
   parameter int  DEPTH = 16
)
(
   input  logic clk,
   input  logic i_rst,
   input  logic i_clear,
   input  T     i_data,
   input  logic i_valid,
   output logic o_ready,
   output T     o_data,
   output logic o_valid,
   input  logic i_ready
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   // a full FIFO still takes a write when the head leaves in the same cycle
   assign o_ready = (count != CNT_W'(DEPTH)) || i_ready;
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];

   assign wr_en = i_valid && o_ready;
   assign rd_en = o_valid && i_ready;

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_rst || i_clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // occupancy
         if (wr_en && !rd_en)
         begin
            count <= count + 1'b1;
         end
         else if (rd_en && !wr_en)
         begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- hw/burst_detect_pkg.sv
package burst_detect_pkg;

   // width of one I or Q component
   localparam int SAMPLE_W = 16;

   // truncated correlation component width
   localparam int CORR_W = 24;

   localparam int MAG_W = 16;

   // phase counts per full turn is 2**PHASE_W
   localparam int PHASE_W = 16;

   // samples below threshold before a crossing ends
   localparam int DEBOUNCE = 5;

   typedef struct packed
   {
      logic signed [SAMPLE_W-1:0] i;
      logic signed [SAMPLE_W-1:0] q;
   } iq_t;

   typedef logic [31:0] power_t;

   typedef struct packed
   {
      logic signed [CORR_W-1:0] re;
      logic signed [CORR_W-1:0] im;
   } corr_t;

   // phase in the upper half
   typedef struct packed
   {
      logic [PHASE_W-1:0] phase;
      logic [MAG_W-1:0]   mag;
   } magphase_t;

   typedef struct packed
   {
      logic [15:0]        offset;
      logic [PHASE_W-1:0] phase;
   } burst_t;

endpackage
